// File: hdl/rv_pkg.sv
package rv_pkg;

  // machine word width, also the address width
  localparam int xlen = 64;

  // register index width and register count
  localparam int reg_idx_w = 5;
  localparam int num_regs  = 1 << reg_idx_w;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [31:0]          inst_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // first fetch address after reset
  localparam word_t pc_reset = 64'h0000_0000_8000_0000;

  // sequential fetch step, one 32-bit word
  localparam word_t inst_bytes = 64'd4;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_store  = 7'b0100011,
    op_system = 7'b1110011
  } opcode_e;

  // funct3 codes of the kept subset
  // addi and add/sub share 000
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_jalr = 3'b000;
  // doubleword store only
  localparam logic [2:0] f3_sd   = 3'b011;

  // funct7 for the register-register group
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  // ebreak is matched on the full word
  // imm=1, rs1=0, funct3=0, rd=0, system opcode
  localparam inst_t ebreak_word = 32'h0010_0073;

  // alu operation, picked by the decoder
  typedef enum logic {
    alu_add = 1'b0,
    alu_sub = 1'b1
  } alu_op_e;

endpackage

// File: hdl/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder import rv_pkg::*; (
  input  inst_t    instr,
  output reg_idx_t rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output word_t    imm,
  output alu_op_e  alu_op,
  output logic     use_imm,
  output logic     use_pc,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     is_store,
  output logic     reg_we,
  output logic     is_ebreak,
  output logic     illegal
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  word_t      imm_j;
  logic       known;

  // fixed field positions
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs2    = instr[24:20];

  // sign-extended immediates, one per format
  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  // j format, scrambled bits, lsb always zero
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // defaults: no writeback, no store
    rs1       = instr[19:15];
    imm       = imm_i;
    alu_op    = alu_add;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_store  = 1'b0;
    reg_we    = 1'b1;
    is_ebreak = 1'b0;
    known     = 1'b0;
    case (opcode)
      op_imm: begin
        // addi only
        known   = (funct3 == f3_add);
        use_imm = 1'b1;
      end
      op_reg: begin
        known  = (funct3 == f3_add) && ((funct7 == f7_base) || (funct7 == f7_sub));
        alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
      end
      op_lui: begin
        // rs1 forced to x0, so operand one reads as zero
        rs1     = '0;
        imm     = imm_u;
        use_imm = 1'b1;
        known   = 1'b1;
      end
      op_auipc: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        known   = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        is_jal = 1'b1;
        known  = 1'b1;
      end
      op_jalr: begin
        // target is rs1 + imm_i through the alu
        known   = (funct3 == f3_jalr);
        use_imm = 1'b1;
        is_jalr = 1'b1;
      end
      op_store: begin
        // address rs1 + imm_s, data rs2
        known    = (funct3 == f3_sd);
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = 1'b1;
        reg_we   = 1'b0;
      end
      op_system: begin
        // ecall, csr ops etc. all end up illegal
        known     = (instr == ebreak_word);
        is_ebreak = known;
        reg_we    = 1'b0;
      end
      default: begin
        known = 1'b0;
      end
    endcase
    illegal = !known;
    // nothing may leave the core for an unknown word
    if (illegal) begin
      reg_we   = 1'b0;
      is_store = 1'b0;
    end
  end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    wb_data,
  input  logic     wb_en,
  output word_t    rdata_1,
  output word_t    rdata_2
);

  // x1..x31, x0 has no storage
  word_t regs [1:num_regs-1];

  // single write port, x0 writes dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (rd != '0)) begin
      regs[rd] <= wb_data;
    end
  end

  // combinational reads, x0 hardwired to zero
  // no bypass, the write lands after the read it would serve
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/10ps

module exec_unit import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  word_t   rdata_1,
  input  word_t   rdata_2,
  input  word_t   imm,
  input  alu_op_e alu_op,
  input  logic    use_imm,
  input  logic    use_pc,
  input  logic    is_jal,
  input  logic    is_jalr,
  input  logic    is_store,
  input  logic    reg_we,
  input  logic    is_ebreak,
  input  logic    illegal,
  output word_t   pc,
  output word_t   wb_data,
  output logic    wb_en,
  output logic    dmem_we,
  output word_t   dmem_addr,
  output word_t   dmem_wdata,
  output logic    halted,
  output logic    trap
);

  word_t operand_1;
  word_t operand_2;
  word_t alu_b;
  word_t alu_result;
  word_t pc_plus_4;
  word_t next_pc;
  logic  sub_en;
  logic  advance;

  // operand one: pc for auipc, else rs1
  // lui comes in with rs1 = x0, so this is zero
  assign operand_1 = use_pc ? pc : rdata_1;
  assign operand_2 = use_imm ? imm : rdata_2;

  // single adder, subtract as a + ~b + 1
  assign sub_en     = (alu_op == alu_sub);
  assign alu_b      = sub_en ? ~operand_2 : operand_2;
  assign alu_result = operand_1 + alu_b + {{(xlen-1){1'b0}}, sub_en};

  assign pc_plus_4 = pc + inst_bytes;

  // link value for jumps, alu result for the rest
  assign wb_data = (is_jal || is_jalr) ? pc_plus_4 : alu_result;

  // jal relative to pc, jalr through the alu with bit 0 dropped
  always_comb begin
    if (is_jal) begin
      next_pc = pc + imm;
    end else if (is_jalr) begin
      next_pc = {alu_result[xlen-1:1], 1'b0};
    end else begin
      next_pc = pc_plus_4;
    end
  end

  // store port, sampled by the memory on the next edge
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rdata_2;

  // halted blocks every side effect
  assign wb_en   = reg_we && !halted;
  assign dmem_we = is_store && !halted;

  // pc stays on the ebreak or illegal word
  assign advance = !halted && !is_ebreak && !illegal;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= pc_reset;
    end else if (advance) begin
      pc <= next_pc;
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
      trap   <= 1'b0;
    end else if (!halted) begin
      if (illegal) begin
        halted <= 1'b1;
        trap   <= 1'b1;
      end else if (is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  // frozen pc once stopped
  a_pc_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc)
  ) else $error("pc moved while halted");

  // ebreak stops on its own address, no trap
  a_ebreak_stop: assert property (
    @(posedge clk) disable iff (!rst_n)
    (is_ebreak && !halted) |=> (halted && !trap && (pc == $past(pc)))
  ) else $error("ebreak did not halt in place");

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  inst_t imem_data,
  output word_t imem_addr,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_we,
  output logic  halted,
  output logic  trap
);

  // decoder outputs
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;
  alu_op_e  alu_op;
  logic     use_imm;
  logic     use_pc;
  logic     is_jal;
  logic     is_jalr;
  logic     is_store;
  logic     reg_we;
  logic     is_ebreak;
  logic     illegal;

  // register file read data and writeback
  word_t rdata_1;
  word_t rdata_2;
  word_t wb_data;
  logic  wb_en;

  // decode the fetched word
  inst_decoder u_inst_decoder (
    .instr     (imem_data),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_store  (is_store),
    .reg_we    (reg_we),
    .is_ebreak (is_ebreak),
    .illegal   (illegal)
  );

  // reads alongside the decoder, write gated by the execute unit
  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .wb_data (wb_data),
    .wb_en   (wb_en),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // alu, pc and halt state, pc doubles as the fetch address
  exec_unit u_exec_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .is_store   (is_store),
    .reg_we     (reg_we),
    .is_ebreak  (is_ebreak),
    .illegal    (illegal),
    .pc         (imem_addr),
    .wb_data    (wb_data),
    .wb_en      (wb_en),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .halted     (halted),
    .trap       (trap)
  );

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 16
) (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  int unsigned held;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    held  = 0;
  end

  always #(period_ns / 2) clk = ~clk;

  // request pulls reset low at once
  // release after reset_cycles rising edges, on an edge
  always @(posedge clk or posedge rst_req) begin
    if (rst_req) begin
      rst_n <= 1'b0;
      held  <= 0;
    end else if (!rst_n) begin
      held <= held + 1;
      if (held == reset_cycles - 1) begin
        rst_n <= 1'b1;
      end
    end
  end

endmodule

// File: verification/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

  localparam int n_tests      = 6;
  localparam int n_words      = 42;
  localparam int n_stores     = 12;
  localparam int reset_cycles = 16;
  // reset plus halt detection per test
  localparam int halt_margin  = 20;

  logic  clk;
  logic  rst_n;
  logic  rst_req;
  inst_t imem_data = '0;
  word_t imem_addr;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  logic  halted;
  logic  trap;

  // instruction memory, byte address to word
  inst_t imem [word_t];

  int cycle_count;
  int timeout_limit;

  // one row per test
  string test_name [n_tests] = '{"arith", "x0_zero", "upper_imm", "jumps", "halt", "illegal"};
  int    prog_len  [n_tests] = '{10, 7, 8, 7, 5, 5};
  int    st_count  [n_tests] = '{3, 2, 3, 2, 1, 1};
  bit    exp_trap  [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  // pc where the core stops, ebreak or illegal word
  word_t stop_pc   [n_tests] = '{64'h8000_0024, 64'h8000_0018, 64'h8000_001c,
                                 64'h8000_0010, 64'h8000_000c, 64'h8000_000c};

  // programs back to back, each placed from pc_reset
  inst_t prog_words [n_words] = '{
    // arith: x10=0x200, x1=100, x2=7, x3=x1+x2, x4=x2-x1, x5=x1-1
    32'h2000_0513, 32'h0640_0093, 32'h0070_0113, 32'h0020_81b3, 32'h4011_0233,
    32'hfff0_8293, 32'h0035_3023, 32'h0045_3423, 32'h0055_3823, 32'h0010_0073,
    // x0_zero: addi x0 then sd x0, add x0 then sd x0
    32'h3000_0513, 32'h0370_0013, 32'h0005_3023, 32'h0050_0093, 32'h0010_8033,
    32'h0005_3423, 32'h0010_0073,
    // upper_imm: lui x1, auipc x2 at 0x80000008, lui x3 negative
    32'h4000_0513, 32'h1234_50b7, 32'h0000_1117, 32'hffff_f1b7, 32'h0015_3023,
    32'h0025_3423, 32'h0035_3823, 32'h0010_0073,
    // jumps: jal x1 +20 over an sd, jalr x5 1(x1) back to 0x80000008
    32'h5000_0513, 32'h0140_00ef, 32'h0015_3423, 32'h0055_3823, 32'h0010_0073,
    32'h0005_3023, 32'h0010_82e7,
    // halt: one store, ebreak, then an sd that never runs
    32'h6000_0513, 32'h0010_0093, 32'h0015_3023, 32'h0010_0073, 32'h0015_3423,
    // illegal: lw is outside the subset, sd behind it never runs
    32'h7000_0513, 32'h0030_0093, 32'h0015_3023, 32'h0005_2103, 32'h0015_3423
  };

  // expected stores in program order
  word_t st_addr [n_stores] = '{
    64'h200, 64'h208, 64'h210,
    64'h300, 64'h308,
    64'h400, 64'h408, 64'h410,
    64'h508, 64'h510,
    64'h600,
    64'h700
  };
  word_t st_data [n_stores] = '{
    64'h6b, 64'hffff_ffff_ffff_ffa3, 64'h63,
    64'h0, 64'h0,
    64'h1234_5000, 64'h8000_1008, 64'hffff_ffff_ffff_f000,
    64'h8000_0008, 64'h8000_001c,
    64'h1,
    64'h3
  };

  clk_gen #(
    .period_ns    (10),
    .reset_cycles (reset_cycles)
  ) u_clk_gen (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  rv_core DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_data  (imem_data),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halted     (halted),
    .trap       (trap)
  );

  // fetch answer, settles well before the next rising edge
  // unloaded addresses read as zero, which decodes illegal
  always @(negedge clk) begin
    if (imem.exists(imem_addr)) begin
      imem_data = imem[imem_addr];
    end else begin
      imem_data = '0;
    end
  end

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string test, input string what,
                            input word_t expected, input word_t actual);
    if (actual !== expected) begin
      fail_stop($sformatf("[ERROR] %s %s: expected %h, actual %h",
                          test, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input bit expected, input logic actual);
    if (actual !== expected) begin
      fail_stop($sformatf("[ERROR] %s %s: expected %b, actual %b",
                          test, what, expected, actual));
    end
  endtask

  // hung core guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      fail_stop($sformatf("core hung, no halt after %0d cycles", cycle_count));
    end
  end

  task automatic run_test(input int t, input int word_base, input int store_base);
    int seen;
    seen = 0;
    $display("running %s", test_name[t]);
    // program goes in while reset is held
    @(negedge clk);
    rst_req = 1'b1;
    imem.delete();
    for (int i = 0; i < prog_len[t]; i++) begin
      imem[pc_reset + word_t'(4 * i)] = prog_words[word_base + i];
    end
    @(negedge clk);
    rst_req = 1'b0;
    wait (rst_n === 1'b1);
    check_word(test_name[t], "reset pc", pc_reset, imem_addr);
    // halt state from the previous test must be gone
    check_flag(test_name[t], "reset halted", 1'b0, halted);
    check_flag(test_name[t], "reset trap", 1'b0, trap);
    // values seen at the edge are the ones the edge takes
    while (halted !== 1'b1) begin
      @(posedge clk);
      if (dmem_we === 1'b1) begin
        if (seen >= st_count[t]) begin
          fail_stop($sformatf("%s: unexpected store to %h", test_name[t], dmem_addr));
        end else begin
          check_word(test_name[t], "store address", st_addr[store_base + seen], dmem_addr);
          check_word(test_name[t], "store data", st_data[store_base + seen], dmem_wdata);
          seen++;
        end
      end
    end
    check_flag(test_name[t], "trap", exp_trap[t], trap);
    check_word(test_name[t], "stop address", stop_pc[t], imem_addr);
    // stopped core stays quiet and in place
    repeat (2) begin
      @(posedge clk);
      if (dmem_we === 1'b1) begin
        fail_stop($sformatf("%s: store to %h after halt", test_name[t], dmem_addr));
      end
    end
    check_word(test_name[t], "held address", stop_pc[t], imem_addr);
    check_flag(test_name[t], "halted held", 1'b1, halted);
    if (seen != st_count[t]) begin
      fail_stop($sformatf("%s: only %0d of %0d expected stores were seen",
                          test_name[t], seen, st_count[t]));
    end
  endtask

  initial begin
    int word_base;
    int store_base;
    int total_words;
    rst_req     = 1'b0;
    cycle_count = 0;
    total_words = 0;
    for (int t = 0; t < n_tests; t++) begin
      total_words += prog_len[t];
    end
    // every word once, plus reset and halt time per test
    timeout_limit = total_words + n_tests * (reset_cycles + halt_margin);
    word_base     = 0;
    store_base    = 0;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t, word_base, store_base);
      word_base  += prog_len[t];
      store_base += st_count[t];
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: tb.f
hdl/rv_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/rv_core.sv
verification/clk_gen.sv
verification/tb_rv_core.sv
